/* files.f */
rtl/hash_pkg.sv
rtl/hash_controller.sv
rtl/round_counter.sv
rtl/hash_round_core.sv
rtl/digest_register.sv
rtl/hash_module.sv
sim/hash_module_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the hash_module testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module hash_module_tb \
	-f files.f \
	-o Vhash_module_tb

./obj_dir/Vhash_module_tb | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

/* sim/hash_module_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hash_module_tb;

	// a request needs 3*(n_rounds+2)+2 edges, so 70 cycles covers one with room to spare.
	localparam int cycle_limit = 40 * (3 * (hash_pkg::n_rounds + 2) + 16) + 200;
	localparam int ack_latency = 3 * (hash_pkg::n_rounds + 2) + 2;

	logic clk;
	logic n_rst;
	logic req;
	logic abort;
	logic [hash_pkg::word_w-1:0] msg_0;
	logic [hash_pkg::word_w-1:0] msg_1;
	logic [hash_pkg::word_w-1:0] msg_2;
	logic ack;
	logic [hash_pkg::word_w-1:0] digest;

	int value_errors = 0;
	int protocol_errors = 0;
	int cycle_count = 0;
	logic [31:0] lcg_state = 32'hd89e079e;
	logic [hash_pkg::word_w-1:0] expect_q[$]; // digests owed by requests in flight.
	string name_q[$];

	hash_module i_hash_module (
		.clk(clk),
		.n_rst(n_rst),
		.req(req),
		.abort(abort),
		.msg_0(msg_0),
		.msg_1(msg_1),
		.msg_2(msg_2),
		.ack(ack),
		.digest(digest)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// three passes of n_rounds rounds where each pass chains off the one before.
	function automatic logic [hash_pkg::word_w-1:0] expected_digest(
		input logic [hash_pkg::word_w-1:0] m0,
		input logic [hash_pkg::word_w-1:0] m1,
		input logic [hash_pkg::word_w-1:0] m2);
		logic [hash_pkg::word_w-1:0] m;
		logic [hash_pkg::word_w-1:0] s;
		logic [hash_pkg::word_w-1:0] t;
		logic [hash_pkg::word_w-1:0] k;
		logic [hash_pkg::word_w-1:0] prev;
		prev = hash_pkg::hash_iv;
		for (int p = 0; p < hash_pkg::n_passes; p++) begin
			m = (p == 0) ? m0 : ((p == 1) ? m1 : m2);
			s = (p == 0) ? hash_pkg::hash_iv : (prev ^ hash_pkg::hash_iv);
			for (int r = 0; r < hash_pkg::n_rounds; r++) begin
				k = 32'(r) * 32'h9e3779b9; // round index times the golden ratio step.
				t = s + (m ^ k);
				s = (t << hash_pkg::rot_amount)
					| (t >> (hash_pkg::word_w - hash_pkg::rot_amount));
			end
			prev = s;
		end
		return prev;
	endfunction

	task automatic check_digest(input string name, input logic [hash_pkg::word_w-1:0] expected,
		input logic [hash_pkg::word_w-1:0] actual);
		if (actual !== expected) begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error: %s expected %b actual %b", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("error: %s expected %0d actual %0d", name, expected, actual);
			value_errors++;
		end
	endtask

	// one full four-phase handshake; hold keeps req high that many cycles after ack.
	task automatic run_request(input string name, input logic [hash_pkg::word_w-1:0] m0,
		input logic [hash_pkg::word_w-1:0] m1, input logic [hash_pkg::word_w-1:0] m2,
		input int hold, output int edges);
		logic [hash_pkg::word_w-1:0] held;
		expect_q.push_back(expected_digest(m0, m1, m2));
		name_q.push_back(name);
		@(posedge clk);
		#1;
		msg_0 = m0;
		msg_1 = m1;
		msg_2 = m2;
		req = 1'b1;
		edges = 0;
		do begin
			@(posedge clk);
			edges++; // the first edge counted is the one that samples req.
			@(negedge clk);
		end while (!ack && edges < 2 * ack_latency);
		if (!ack) begin
			$display("%s: ack did not rise within %0d cycles", name, 2 * ack_latency);
			protocol_errors++;
		end
		held = digest;
		repeat (hold) begin
			@(negedge clk);
			check_bit({name, " ack held"}, 1'b1, ack);
			check_digest({name, " digest held"}, held, digest);
		end
		@(posedge clk);
		#1 req = 1'b0;
		@(negedge clk);
		check_bit({name, " ack before req sampled low"}, 1'b1, ack);
		@(negedge clk);
		check_bit({name, " ack after req sampled low"}, 1'b0, ack);
	endtask

	// abort in the middle of pass two, then keep req high so a late ack would show.
	task automatic run_aborted(input logic [hash_pkg::word_w-1:0] m0);
		@(posedge clk);
		#1;
		msg_0 = m0;
		msg_1 = ~m0;
		msg_2 = m0 ^ 32'h5a5a5a5a;
		req = 1'b1;
		repeat (hash_pkg::n_rounds + 9) @(posedge clk);
		#1 abort = 1'b1;
		@(posedge clk);
		#1 abort = 1'b0;
		repeat (3 * ack_latency / 2) begin
			@(negedge clk);
			check_bit("abort ack stays low", 1'b0, ack);
		end
		@(posedge clk);
		#1 req = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// every ack rise must settle one pending digest.
	initial begin
		logic ack_prev;
		ack_prev = 1'b0;
		forever begin
			@(negedge clk);
			if (ack && !ack_prev) begin
				if (expect_q.size() == 0) begin
					$display("ack rose with no request pending");
					protocol_errors++;
				end else begin
					check_digest(name_q.pop_front(), expect_q.pop_front(), digest);
				end
			end
			ack_prev = ack;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: test did not finish within %0d cycles", cycle_limit);
			$display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int latency;
		logic [hash_pkg::word_w-1:0] w0;
		logic [hash_pkg::word_w-1:0] w1;
		logic [hash_pkg::word_w-1:0] w2;
		n_rst = 1'b0;
		req = 1'b0;
		abort = 1'b0;
		msg_0 = '0;
		msg_1 = '0;
		msg_2 = '0;
		repeat (4) @(posedge clk);
		#1 n_rst = 1'b1;
		repeat (100) begin
			@(negedge clk);
			check_bit("reset ack", 1'b0, ack);
		end
		run_request("known vector", '0, '0, '0, 0, latency);
		check_count("known vector latency", ack_latency, latency);
		for (int i = 0; i < 30; i++) begin
			lcg_state = lcg_next(lcg_state);
			w0 = lcg_state;
			lcg_state = lcg_next(lcg_state);
			w1 = lcg_state;
			lcg_state = lcg_next(lcg_state);
			w2 = lcg_state;
			run_request($sformatf("random %0d", i), w0, w1, w2, 0, latency);
		end
		run_request("hold", w2, w0, w1, 20, latency);
		lcg_state = lcg_next(lcg_state);
		run_aborted(lcg_state);
		run_request("after abort", w1, w2, w0, 0, latency);
		repeat (4) @(negedge clk);
		if (expect_q.size() != 0) begin
			$display("%0d digests were never returned", expect_q.size());
			protocol_errors++;
		end
		$display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/hash_module.sv */
`timescale 1ns/1ps
`default_nettype none

module hash_module (
	input logic clk,
	input logic n_rst,
	input logic req,
	input logic abort,
	input logic [hash_pkg::word_w-1:0] msg_0,
	input logic [hash_pkg::word_w-1:0] msg_1,
	input logic [hash_pkg::word_w-1:0] msg_2,
	output logic ack,
	output logic [hash_pkg::word_w-1:0] digest
);

	logic init;
	logic cnt_up;
	logic halt;
	logic out_load;
	logic rollover;
	logic [hash_pkg::sel_w-1:0] hash_select;
	logic [hash_pkg::round_w-1:0] round_idx;
	logic [hash_pkg::word_w-1:0] core_state;
	logic [hash_pkg::word_w-1:0] chain_value;

	hash_controller i_hash_controller (
		.clk(clk),
		.n_rst(n_rst),
		.req(req),
		.abort(abort),
		.rollover(rollover),
		.init(init),
		.cnt_up(cnt_up),
		.halt(halt),
		.out_load(out_load),
		.ack(ack),
		.hash_select(hash_select)
	);

	round_counter i_round_counter (
		.clk(clk),
		.n_rst(n_rst),
		.init(init),
		.cnt_up(cnt_up),
		.round_idx(round_idx),
		.rollover(rollover)
	);

	hash_round_core i_hash_round_core (
		.clk(clk),
		.n_rst(n_rst),
		.init(init),
		.halt(halt),
		.hash_select(hash_select),
		.round_idx(round_idx),
		.msg_0(msg_0),
		.msg_1(msg_1),
		.msg_2(msg_2),
		.chain_value(chain_value),
		.core_state(core_state)
	);

	digest_register i_digest_register (
		.clk(clk),
		.n_rst(n_rst),
		.out_load(out_load),
		.core_state(core_state),
		.chain_value(chain_value),
		.digest(digest)
	);

endmodule

`default_nettype wire

/* rtl/digest_register.sv */
`timescale 1ns/1ps
`default_nettype none

module digest_register (
	input logic clk,
	input logic n_rst,
	input logic out_load,
	input logic [hash_pkg::word_w-1:0] core_state,
	output logic [hash_pkg::word_w-1:0] chain_value,
	output logic [hash_pkg::word_w-1:0] digest
);

	logic [hash_pkg::word_w-1:0] pass_result; // result of the latest finished pass.

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			pass_result <= hash_pkg::hash_iv;
		end else if (out_load) begin
			pass_result <= core_state; // taken on the edge that ends an out step.
		end
	end

	// the same value feeds the next pass and, after pass three, the requester.
	assign chain_value = pass_result;
	assign digest = pass_result;

endmodule

`default_nettype wire

/* rtl/hash_round_core.sv */
`timescale 1ns/1ps
`default_nettype none

module hash_round_core (
	input logic clk,
	input logic n_rst,
	input logic init,
	input logic halt,
	input logic [hash_pkg::sel_w-1:0] hash_select,
	input logic [hash_pkg::round_w-1:0] round_idx,
	input logic [hash_pkg::word_w-1:0] msg_0,
	input logic [hash_pkg::word_w-1:0] msg_1,
	input logic [hash_pkg::word_w-1:0] msg_2,
	input logic [hash_pkg::word_w-1:0] chain_value,
	output logic [hash_pkg::word_w-1:0] core_state
);

	logic [hash_pkg::word_w-1:0] msg_word;
	logic [hash_pkg::word_w-1:0] idx_ext;
	logic [hash_pkg::word_w-1:0] round_const;
	logic [hash_pkg::word_w-1:0] sum;
	logic [hash_pkg::word_w-1:0] round_out;
	logic [hash_pkg::word_w-1:0] start_value;

	always_comb begin
		case (hash_select)
			2'd0: msg_word = msg_0;
			2'd1: msg_word = msg_1;
			default: msg_word = msg_2;
		endcase
	end

	assign idx_ext = {{(hash_pkg::word_w - hash_pkg::round_w){1'b0}}, round_idx};
	assign round_const = idx_ext * hash_pkg::round_step; // wraps mod 2^32.

	// one round is rotl(state + (msg ^ k), rot_amount).
	assign sum = core_state + (msg_word ^ round_const);
	assign round_out = {sum[hash_pkg::word_w-hash_pkg::rot_amount-1:0],
		sum[hash_pkg::word_w-1:hash_pkg::word_w-hash_pkg::rot_amount]};

	// later passes chain off the result of the pass before.
	assign start_value = (hash_select == '0) ? hash_pkg::hash_iv
		: (chain_value ^ hash_pkg::hash_iv);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			core_state <= hash_pkg::hash_iv;
		end else if (init) begin
			core_state <= start_value;
		end else if (!halt) begin
			core_state <= round_out;
		end
	end

	a_sel_range: assert property (@(posedge clk) disable iff (!n_rst)
		hash_select < hash_pkg::n_passes);

endmodule

`default_nettype wire

/* rtl/round_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module round_counter (
	input logic clk,
	input logic n_rst,
	input logic init,
	input logic cnt_up,
	output logic [hash_pkg::round_w-1:0] round_idx,
	output logic rollover
);

	logic at_last; // round_idx sits on the final round of a pass.

	assign at_last = (round_idx == hash_pkg::last_round);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			round_idx <= '0;
		end else if (init) begin
			round_idx <= '0; // every pass starts at round zero.
		end else if (cnt_up) begin
			if (at_last) begin
				round_idx <= '0;
			end else begin
				round_idx <= round_idx + 1'b1;
			end
		end
	end

	// seen by the controller in the same cycle as the last round.
	assign rollover = cnt_up && at_last;

	a_idx_hold: assert property (@(posedge clk) disable iff (!n_rst)
		(!cnt_up && !init) |=> $stable(round_idx));

endmodule

`default_nettype wire

/* rtl/hash_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module hash_controller (
	input logic clk,
	input logic n_rst,
	input logic req,
	input logic abort,
	input logic rollover,
	output logic init,
	output logic cnt_up,
	output logic halt,
	output logic out_load,
	output logic ack,
	output logic [hash_pkg::sel_w-1:0] hash_select
);

	hash_pkg::ctrl_state_t state;
	hash_pkg::ctrl_state_t next_state;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= hash_pkg::st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			hash_pkg::st_idle: begin
				if (req && !ack) begin
					next_state = hash_pkg::st_init_1;
				end
			end
			hash_pkg::st_init_1: next_state = hash_pkg::st_calc_1;
			hash_pkg::st_calc_1: begin
				if (rollover) begin
					next_state = hash_pkg::st_out_1;
				end
			end
			hash_pkg::st_out_1: next_state = hash_pkg::st_init_2;
			hash_pkg::st_init_2: next_state = hash_pkg::st_calc_2;
			hash_pkg::st_calc_2: begin
				if (rollover) begin
					next_state = hash_pkg::st_out_2;
				end
			end
			hash_pkg::st_out_2: next_state = hash_pkg::st_init_3;
			hash_pkg::st_init_3: next_state = hash_pkg::st_calc_3;
			hash_pkg::st_calc_3: begin
				if (rollover) begin
					next_state = hash_pkg::st_out_3;
				end
			end
			hash_pkg::st_out_3: next_state = hash_pkg::st_hash_check;
			hash_pkg::st_hash_check: next_state = hash_pkg::st_release;
			hash_pkg::st_release, hash_pkg::st_aborted: begin
				if (!req) begin // the requester has closed the handshake.
					next_state = hash_pkg::st_idle;
				end
			end
			default: next_state = hash_pkg::st_idle;
		endcase

		// abort wins over every other transition.
		if (abort) begin
			next_state = hash_pkg::st_aborted;
		end
	end

	always_comb begin
		init = 1'b0;
		cnt_up = 1'b0;
		halt = 1'b1; // the core only moves in a calc state.
		out_load = 1'b0;
		ack = 1'b0;
		case (state)
			hash_pkg::st_init_1, hash_pkg::st_init_2, hash_pkg::st_init_3: begin
				init = 1'b1;
			end
			hash_pkg::st_calc_1, hash_pkg::st_calc_2, hash_pkg::st_calc_3: begin
				cnt_up = 1'b1;
				halt = 1'b0;
			end
			hash_pkg::st_out_1, hash_pkg::st_out_2, hash_pkg::st_out_3: begin
				out_load = 1'b1;
			end
			hash_pkg::st_release: ack = 1'b1;
			default: ;
		endcase
	end

	// the pass number is held over the init, calc and out steps of each pass.
	always_comb begin
		case (state)
			hash_pkg::st_init_2, hash_pkg::st_calc_2, hash_pkg::st_out_2: begin
				hash_select = 2'd1;
			end
			hash_pkg::st_init_3, hash_pkg::st_calc_3, hash_pkg::st_out_3: begin
				hash_select = 2'd2;
			end
			default: hash_select = 2'd0;
		endcase
	end

	// the counter restart and the first round must not share a cycle.
	a_init_not_cnt: assert property (@(posedge clk) disable iff (!n_rst)
		!(init && cnt_up));

	// under the four-phase rule ack drops only once req is gone or on abort.
	a_ack_falls_late: assert property (@(posedge clk) disable iff (!n_rst)
		$fell(ack) |-> (!$past(req) || $past(abort)));

endmodule

`default_nettype wire

/* rtl/hash_pkg.sv */
`default_nettype none

package hash_pkg;

	localparam int word_w = 32; // message words, working state and digest.
	localparam int n_rounds = 16; // rounds in one compression pass.
	localparam int round_w = 4; // wide enough for 0 .. n_rounds-1.
	localparam int n_passes = 3; // one pass per message word.
	localparam int sel_w = 2; // wide enough for the pass number.

	// index of the round on which the counter wraps back to zero.
	localparam logic [round_w-1:0] last_round = round_w'(n_rounds - 1);

	localparam logic [word_w-1:0] hash_iv = 32'h6a09e667; // start value of pass 0.
	localparam logic [word_w-1:0] round_step = 32'h9e3779b9; // times round index.
	localparam int rot_amount = 5; // left rotate applied at the end of a round.

	// the controller runs one init/calc/out triple per pass.
	typedef enum logic [3:0] {
		st_idle,
		st_init_1,
		st_calc_1,
		st_out_1,
		st_init_2,
		st_calc_2,
		st_out_2,
		st_init_3,
		st_calc_3,
		st_out_3,
		st_hash_check,
		st_release, // ack is high here until req drops.
		st_aborted
	} ctrl_state_t;

endpackage

`default_nettype wire
